//--- include/muldiv_consts.svh
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Operand and result width
`define MULDIV_XLEN 32

// Destination register index width
`define MULDIV_RD_W 5

// Default number of waiting requests
`define MULDIV_FIFO_DEPTH 4

// Stored request: op, rd, arga, argb
`define MULDIV_REQ_W (3 + `MULDIV_RD_W + 2 * `MULDIV_XLEN)

`endif

//--- run.sh
#!/bin/sh
# Build the offload testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_muldiv_offload \
  -f verilog.f \
  -o tb_muldiv_offload

./obj_dir/tb_muldiv_offload

//--- verification/tb_muldiv_offload.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_consts.svh"

module tb_muldiv_offload;

  localparam int NUM_PAIRS  = 8;
  localparam int NUM_RANDOM = 200;
  // Requests times 80 cycles each, plus room for the stall phases
  localparam int WATCHDOG_CYCLES = (8 * NUM_PAIRS + 10 + NUM_RANDOM) * 80 + 2000;

  // Directed pairs with signed extremes, zero divisors and the overflow pair
  localparam logic [31:0] MUL_A [NUM_PAIRS] = '{32'd3, 32'hfffffffd, 32'hfffffffd,
      32'h80000000, 32'hffffffff, 32'h7fffffff, 32'h12345678, 32'h0};
  localparam logic [31:0] MUL_B [NUM_PAIRS] = '{32'd7, 32'd7, 32'hfffffff9,
      32'h80000000, 32'hffffffff, 32'h80000000, 32'h9abcdef0, 32'hdeadbeef};
  localparam logic [31:0] DIV_A [NUM_PAIRS] = '{32'd100, 32'hffffff9c, 32'd100,
      32'hffffff9c, 32'd7, 32'd5, 32'h80000000, 32'h80000000};
  localparam logic [31:0] DIV_B [NUM_PAIRS] = '{32'd7, 32'd7, 32'hfffffff9,
      32'hfffffff9, 32'd100, 32'h0, 32'h0, 32'hffffffff};

  logic                      clk;
  logic                      rst_n_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  muldiv_pkg::muldiv_op_e    req_op_i;
  logic [`MULDIV_RD_W-1:0]   req_rd_i;
  logic [`MULDIV_XLEN-1:0]   req_arga_i;
  logic [`MULDIV_XLEN-1:0]   req_argb_i;
  logic                      rsp_valid_o;
  logic                      rsp_ready_i;
  logic [`MULDIV_RD_W-1:0]   rsp_rd_o;
  logic [`MULDIV_XLEN-1:0]   rsp_data_o;

  logic [31:0]               lfsr_state;
  // Completion is in order, so the fronts of these queues are the next result
  logic [`MULDIV_RD_W-1:0]   exp_rd_q [$];
  logic [`MULDIV_XLEN-1:0]   exp_data_q [$];

  muldiv_offload_top muldiv_offload_top_inst (.*);

  always #50 clk = ~clk;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "Simulation did not finish in time");
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // RISC-V M results, including divide by zero and signed overflow
  function automatic logic [31:0] model_result(input muldiv_pkg::muldiv_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [63:0] res;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      muldiv_pkg::MUL, muldiv_pkg::MULH: res = sa * sb;
      muldiv_pkg::MULHSU: res = sa * longint'(b);
      muldiv_pkg::MULHU: res = longint'(a) * longint'(b);
      muldiv_pkg::DIV: res = (b == 0) ? '1 : (a == 32'h80000000 && b == '1) ? 64'(a) :
                             $unsigned(sa / sb);
      muldiv_pkg::DIVU: res = (b == 0) ? '1 : 64'(a / b);
      muldiv_pkg::REM: res = (b == 0) ? 64'(a) : (b == '1) ? 64'd0 : $unsigned(sa % sb);
      default: res = (b == 0) ? 64'(a) : 64'(a % b);
    endcase
    if (op inside {muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU}) begin
      return res[63:32];
    end
    return res[31:0];
  endfunction

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "%s", msg);
  endtask

  // Offer one request and wait for its transfer
  task automatic send_req(input muldiv_pkg::muldiv_op_e op, input logic [4:0] rd,
                          input logic [31:0] a, input logic [31:0] b);
    logic taken;
    taken = 1'b0;
    req_valid_i = 1'b1;
    req_op_i = op;
    req_rd_i = rd;
    req_arga_i = a;
    req_argb_i = b;
    while (!taken) begin
      @(negedge clk);
      taken = req_ready_o;
      @(posedge clk);
      #1;
    end
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(model_result(op, a, b));
    req_valid_i = 1'b0;
  endtask

  // Wait for one response, ready either always high or LFSR driven
  task automatic recv_rsp(input logic random_ready);
    logic done;
    done = 1'b0;
    while (!done) begin
      rsp_ready_i = random_ready ? (rand_bits(1) != 0) : 1'b1;
      @(negedge clk);
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_rd_q.size() == 0) begin
          abort_run("A response arrived with no request outstanding");
        end
        check_eq("rsp_rd_o", 32'(rsp_rd_o), 32'(exp_rd_q.pop_front()));
        check_eq("rsp_data_o", rsp_data_o, exp_data_q.pop_front());
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    rsp_ready_i = 1'b0;
  endtask

  task automatic test_reset();
    logic ready_seen;
    int   waited;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_eq("req_ready_o", 32'(req_ready_o), 32'd0);
    @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    ready_seen = 1'b0;
    for (waited = 0; waited < 4 && !ready_seen; waited++) begin
      @(negedge clk);
      check_eq("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
      ready_seen = req_ready_o;
      @(posedge clk);
      #1;
    end
    if (!ready_seen) begin
      abort_run("req_ready_o did not rise after reset was released");
    end
  endtask

  // Four multiply or four divide operations over all directed pairs
  task automatic run_pairs(input logic is_div, input logic random_ready);
    int i;
    fork
      begin
        for (i = 0; i < 4 * NUM_PAIRS; i++) begin
          send_req(muldiv_pkg::muldiv_op_e'({is_div, 2'(i / NUM_PAIRS)}), 5'((i % 31) + 1),
                   is_div ? DIV_A[i % NUM_PAIRS] : MUL_A[i % NUM_PAIRS],
                   is_div ? DIV_B[i % NUM_PAIRS] : MUL_B[i % NUM_PAIRS]);
        end
      end
      repeat (4 * NUM_PAIRS) recv_rsp(random_ready);
    join
  endtask

  task automatic test_backpressure();
    logic [31:0] data0;
    logic [31:0] rd0;
    int          i;
    rsp_ready_i = 1'b0;
    // One in the unit and four waiting fill the buffer
    for (i = 1; i <= 5; i++) begin
      send_req(muldiv_pkg::MULHU, 5'(i), 32'(i) * 32'h01010101, 32'hf0f0f0f0 - 32'(i));
    end
    req_valid_i = 1'b1;
    req_op_i = muldiv_pkg::DIVU;
    req_rd_i = 5'd6;
    req_arga_i = 32'hcafef00d;
    req_argb_i = 32'd6;
    i = 0;
    @(negedge clk);
    while (!rsp_valid_o) begin
      i++;
      if (i > 80) begin
        abort_run("No response became valid while responses were stalled");
      end
      @(negedge clk);
    end
    data0 = rsp_data_o;
    rd0 = 32'(rsp_rd_o);
    repeat (100) begin
      @(negedge clk);
      check_eq("rsp_valid_o", 32'(rsp_valid_o), 32'd1);
      check_eq("rsp_data_o", rsp_data_o, data0);
      check_eq("rsp_rd_o", 32'(rsp_rd_o), rd0);
      check_eq("req_ready_o", 32'(req_ready_o), 32'd0);
    end
    @(posedge clk);
    #1;
    fork
      send_req(muldiv_pkg::DIVU, 5'd6, 32'hcafef00d, 32'd6);
      repeat (6) recv_rsp(1'b0);
    join
  endtask

  task automatic test_hazard();
    time t0;
    int  i;
    rsp_ready_i = 1'b0;
    send_req(muldiv_pkg::MUL, 5'd7, 32'd1234, 32'd5678);
    // x0 is never pending, so both go through on their first cycle
    for (i = 0; i < 2; i++) begin
      t0 = $time;
      send_req(muldiv_pkg::REMU, 5'd0, 32'd1000 + 32'(i), 32'd7);
      check_eq("x0 request wait cycles", 32'(($time - t0) / 100), 32'd1);
    end
    req_valid_i = 1'b1;
    req_op_i = muldiv_pkg::DIV;
    req_rd_i = 5'd7;
    req_arga_i = 32'hfffff000;
    req_argb_i = 32'd16;
    repeat (60) begin
      @(negedge clk);
      check_eq("req_ready_o", 32'(req_ready_o), 32'd0);
    end
    @(posedge clk);
    #1;
    fork
      begin
        // First x7 result leaves at the next edge, x7 is free one edge later
        t0 = $time;
        send_req(muldiv_pkg::DIV, 5'd7, 32'hfffff000, 32'd16);
        check_eq("x7 request wait cycles", 32'(($time - t0) / 100), 32'd2);
      end
      repeat (4) recv_rsp(1'b1);
    join
  endtask

  task automatic test_random();
    logic [4:0]  start;
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    fork
      begin
        for (i = 0; i < NUM_RANDOM; i++) begin
          // Bursts of eight requests to distinct registers
          if (i % 8 == 0) begin
            start = 5'(rand_bits(5));
          end
          a = (rand_bits(2) == 0) ? 32'h80000000 - 32'(rand_bits(1)) : rand_bits(32);
          b = (rand_bits(2) == 0) ? 32'(rand_bits(1)) - 32'd1 : rand_bits(32);
          send_req(muldiv_pkg::muldiv_op_e'(3'(rand_bits(3))), start + 5'(i % 8), a, b);
        end
      end
      repeat (NUM_RANDOM) recv_rsp(1'b1);
    join
  endtask

  initial begin
    clk = 1'b0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i = muldiv_pkg::MUL;
    req_rd_i = '0;
    req_arga_i = '0;
    req_argb_i = '0;
    rsp_ready_i = 1'b0;
    lfsr_state = 32'h8922d42c;
    test_reset();
    run_pairs(1'b0, 1'b0);
    run_pairs(1'b1, 1'b1);
    test_backpressure();
    test_hazard();
    test_random();
    if (exp_rd_q.size() != 0) begin
      abort_run("Some requests never got a response");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
verilog/muldiv_pkg.sv
verilog/acc_issue.sv
verilog/acc_req_fifo.sv
verilog/muldiv_unit.sv
verilog/muldiv_offload_top.sv
verification/tb_muldiv_offload.sv

//--- verilog/acc_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_consts.svh"

module acc_issue (
  input  logic                          clk,
  input  logic                          rst_n_i,
  // Offload request from the core
  input  logic                          req_valid_i,
  input  muldiv_pkg::muldiv_op_e        req_op_i,
  input  logic [`MULDIV_RD_W-1:0]       req_rd_i,
  input  logic [`MULDIV_XLEN-1:0]       req_arga_i,
  input  logic [`MULDIV_XLEN-1:0]       req_argb_i,
  output logic                          req_ready_o,
  // Request buffer write side
  input  logic                          fifo_full_i,
  output logic                          push_o,
  output muldiv_pkg::muldiv_op_e        push_op_o,
  output logic [`MULDIV_RD_W-1:0]       push_rd_o,
  output logic [`MULDIV_XLEN-1:0]       push_arga_o,
  output logic [`MULDIV_XLEN-1:0]       push_argb_o,
  // Observed response handshake
  input  logic                          rsp_valid_i,
  input  logic                          rsp_ready_i,
  input  logic [`MULDIV_RD_W-1:0]       rsp_rd_i
);

  localparam int NUM_REGS = 1 << `MULDIV_RD_W;

  logic [NUM_REGS-1:0] pending_q;
  logic                active_q;
  logic                rd_busy;
  logic                rsp_done;

  // Goes high on the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // x0 is hardwired to zero and never blocks
  assign rd_busy = (req_rd_i != '0) && pending_q[req_rd_i];

  assign req_ready_o = active_q && !fifo_full_i && !rd_busy;

  assign push_o      = req_valid_i && req_ready_o;
  assign push_op_o   = req_op_i;
  assign push_rd_o   = req_rd_i;
  assign push_arga_o = req_arga_i;
  assign push_argb_o = req_argb_i;

  assign rsp_done = rsp_valid_i && rsp_ready_i;

  // Scoreboard of destination registers with a result in flight
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      if (rsp_done) begin
        pending_q[rsp_rd_i] <= 1'b0;
      end
      // A busy register cannot be accepted, so set and clear never collide
      if (push_o && (req_rd_i != '0)) begin
        pending_q[req_rd_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/acc_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_consts.svh"

module acc_req_fifo #(
  parameter int DEPTH = `MULDIV_FIFO_DEPTH
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  // Write side
  input  logic                          push_i,
  input  muldiv_pkg::muldiv_op_e        push_op_i,
  input  logic [`MULDIV_RD_W-1:0]       push_rd_i,
  input  logic [`MULDIV_XLEN-1:0]       push_arga_i,
  input  logic [`MULDIV_XLEN-1:0]       push_argb_i,
  // Read side
  input  logic                          pop_i,
  output logic                          full_o,
  output logic                          empty_o,
  output muldiv_pkg::muldiv_op_e        head_op_o,
  output logic [`MULDIV_RD_W-1:0]       head_rd_o,
  output logic [`MULDIV_XLEN-1:0]       head_arga_o,
  output logic [`MULDIV_XLEN-1:0]       head_argb_o
);

  localparam int PTR_W   = $clog2(DEPTH);
  localparam int CNT_W   = $clog2(DEPTH + 1);
  localparam int ARGA_LO = `MULDIV_XLEN;
  localparam int RD_LO   = 2 * `MULDIV_XLEN;
  localparam int OP_LO   = RD_LO + `MULDIV_RD_W;

  logic [`MULDIV_REQ_W-1:0] mem_q [DEPTH];
  logic [`MULDIV_REQ_W-1:0] head;
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic                     wr_en;
  logic                     rd_en;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // Pop frees a slot in the same cycle, so push is fine when full
  assign wr_en = push_i && (!full_o || pop_i);
  assign rd_en = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= {push_op_i, push_rd_i, push_arga_i, push_argb_i};
    end
  end

  // Oldest entry
  assign head        = mem_q[rd_ptr_q];
  assign head_op_o   = muldiv_pkg::muldiv_op_e'(head[`MULDIV_REQ_W-1:OP_LO]);
  assign head_rd_o   = head[OP_LO-1:RD_LO];
  assign head_arga_o = head[RD_LO-1:ARGA_LO];
  assign head_argb_o = head[ARGA_LO-1:0];

endmodule

`default_nettype wire

//--- verilog/muldiv_offload_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_consts.svh"

module muldiv_offload_top (
  input  logic                          clk,
  input  logic                          rst_n_i,
  // Offload request port
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  muldiv_pkg::muldiv_op_e        req_op_i,
  input  logic [`MULDIV_RD_W-1:0]       req_rd_i,
  input  logic [`MULDIV_XLEN-1:0]       req_arga_i,
  input  logic [`MULDIV_XLEN-1:0]       req_argb_i,
  // Response port
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output logic [`MULDIV_RD_W-1:0]       rsp_rd_o,
  output logic [`MULDIV_XLEN-1:0]       rsp_data_o
);

  // Issue stage to buffer
  logic                          push;
  muldiv_pkg::muldiv_op_e        push_op;
  logic [`MULDIV_RD_W-1:0]       push_rd;
  logic [`MULDIV_XLEN-1:0]       push_arga;
  logic [`MULDIV_XLEN-1:0]       push_argb;
  logic                          fifo_full;

  // Buffer to arithmetic unit
  logic                          fifo_empty;
  logic                          pop;
  muldiv_pkg::muldiv_op_e        head_op;
  logic [`MULDIV_RD_W-1:0]       head_rd;
  logic [`MULDIV_XLEN-1:0]       head_arga;
  logic [`MULDIV_XLEN-1:0]       head_argb;

  acc_issue acc_issue_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_rd_i     (req_rd_i),
    .req_arga_i   (req_arga_i),
    .req_argb_i   (req_argb_i),
    .req_ready_o  (req_ready_o),
    .fifo_full_i  (fifo_full),
    .push_o       (push),
    .push_op_o    (push_op),
    .push_rd_o    (push_rd),
    .push_arga_o  (push_arga),
    .push_argb_o  (push_argb),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rd_i     (rsp_rd_o)
  );

  acc_req_fifo #(
    .DEPTH (`MULDIV_FIFO_DEPTH)
  ) acc_req_fifo_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .push_op_i    (push_op),
    .push_rd_i    (push_rd),
    .push_arga_i  (push_arga),
    .push_argb_i  (push_argb),
    .pop_i        (pop),
    .full_o       (fifo_full),
    .empty_o      (fifo_empty),
    .head_op_o    (head_op),
    .head_rd_o    (head_rd),
    .head_arga_o  (head_arga),
    .head_argb_o  (head_argb)
  );

  muldiv_unit muldiv_unit_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .empty_i      (fifo_empty),
    .pop_o        (pop),
    .op_i         (head_op),
    .rd_i         (head_rd),
    .arga_i       (head_arga),
    .argb_i       (head_argb),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rd_o     (rsp_rd_o),
    .rsp_data_o   (rsp_data_o)
  );

endmodule

`default_nettype wire

//--- verilog/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

  // RISC-V M-extension operations, encoded as funct3
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } muldiv_op_e;

  // Arithmetic unit FSM
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    CALC = 2'b01,
    DONE = 2'b10
  } muldiv_state_e;

  function automatic logic op_is_div(muldiv_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

  function automatic logic op_is_rem(muldiv_op_e op);
    return op inside {REM, REMU};
  endfunction

  // Operand A is read as two's complement
  function automatic logic op_a_signed(muldiv_op_e op);
    return op inside {MULH, MULHSU, DIV, REM};
  endfunction

  function automatic logic op_b_signed(muldiv_op_e op);
    return op inside {MULH, DIV, REM};
  endfunction

endpackage

`default_nettype wire

//--- verilog/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "muldiv_consts.svh"

module muldiv_unit (
  input  logic                          clk,
  input  logic                          rst_n_i,
  // Request buffer head
  input  logic                          empty_i,
  output logic                          pop_o,
  input  muldiv_pkg::muldiv_op_e        op_i,
  input  logic [`MULDIV_RD_W-1:0]       rd_i,
  input  logic [`MULDIV_XLEN-1:0]       arga_i,
  input  logic [`MULDIV_XLEN-1:0]       argb_i,
  // Result
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output logic [`MULDIV_RD_W-1:0]       rsp_rd_o,
  output logic [`MULDIV_XLEN-1:0]       rsp_data_o
);

  localparam int XLEN  = `MULDIV_XLEN;
  localparam int CNT_W = $clog2(XLEN + 1);

  muldiv_pkg::muldiv_state_e state_q;
  muldiv_pkg::muldiv_op_e    op_q;
  logic [CNT_W-1:0]          cnt_q;
  logic [`MULDIV_RD_W-1:0]   rd_q;
  logic [XLEN-1:0]           opnd_q;
  logic [2*XLEN-1:0]         work_q;
  logic                      neg_q;
  logic [XLEN-1:0]           res_q;

  logic                      a_neg;
  logic                      b_neg;
  logic [XLEN-1:0]           a_mag;
  logic [XLEN-1:0]           b_mag;
  logic                      div_zero;
  logic                      div_ovf;
  logic [XLEN-1:0]           early_res;
  logic [XLEN:0]             mul_sum;
  logic [XLEN:0]             div_shift;
  logic [XLEN:0]             div_diff;
  logic [2*XLEN-1:0]         work_step;
  logic [2*XLEN-1:0]         prod_fix;
  logic [XLEN-1:0]           part_sel;

  assign pop_o = (state_q == muldiv_pkg::IDLE) && !empty_i;

  // Sign capture and magnitudes for the head entry
  assign a_neg = muldiv_pkg::op_a_signed(op_i) && arga_i[XLEN-1];
  assign b_neg = muldiv_pkg::op_b_signed(op_i) && argb_i[XLEN-1];
  assign a_mag = a_neg ? -arga_i : arga_i;
  assign b_mag = b_neg ? -argb_i : argb_i;

  // Corner cases that skip the iteration
  assign div_zero = muldiv_pkg::op_is_div(op_i) && (argb_i == '0);
  assign div_ovf  = (op_i inside {muldiv_pkg::DIV, muldiv_pkg::REM}) &&
                    (arga_i == {1'b1, {(XLEN-1){1'b0}}}) && (argb_i == '1);

  always_comb begin
    if (muldiv_pkg::op_is_rem(op_i)) begin
      early_res = div_zero ? arga_i : '0;
    end else begin
      early_res = div_zero ? '1 : arga_i;
    end
  end

  // One iteration; work_q is {remainder, quotient} when dividing
  always_comb begin
    mul_sum   = {1'b0, work_q[2*XLEN-1:XLEN]} + (work_q[0] ? {1'b0, opnd_q} : '0);
    div_shift = work_q[2*XLEN-1:XLEN-1];
    div_diff  = div_shift - {1'b0, opnd_q};
    if (!muldiv_pkg::op_is_div(op_q)) begin
      work_step = {mul_sum, work_q[XLEN-1:1]};
    end else if (div_diff[XLEN]) begin
      work_step = {div_shift[XLEN-1:0], work_q[XLEN-2:0], 1'b0};
    end else begin
      work_step = {div_diff[XLEN-1:0], work_q[XLEN-2:0], 1'b1};
    end
  end

  // Result select and sign fix-up
  always_comb begin
    prod_fix = neg_q ? -work_q : work_q;
    unique case (op_q)
      muldiv_pkg::MUL: begin
        part_sel = prod_fix[XLEN-1:0];
      end
      muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU: begin
        part_sel = prod_fix[2*XLEN-1:XLEN];
      end
      muldiv_pkg::DIV, muldiv_pkg::DIVU: begin
        part_sel = neg_q ? -work_q[XLEN-1:0] : work_q[XLEN-1:0];
      end
      default: begin
        part_sel = neg_q ? -work_q[2*XLEN-1:XLEN] : work_q[2*XLEN-1:XLEN];
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= muldiv_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        muldiv_pkg::IDLE: begin
          if (pop_o) begin
            cnt_q   <= '0;
            state_q <= (div_zero || div_ovf) ? muldiv_pkg::DONE : muldiv_pkg::CALC;
          end
        end
        muldiv_pkg::CALC: begin
          // XLEN iterations, then one fix-up cycle
          if (cnt_q == CNT_W'(XLEN)) begin
            state_q <= muldiv_pkg::DONE;
          end
          cnt_q <= cnt_q + 1'b1;
        end
        muldiv_pkg::DONE: begin
          if (rsp_ready_i) begin
            state_q <= muldiv_pkg::IDLE;
          end
        end
        default: begin
          state_q <= muldiv_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      op_q  <= op_i;
      rd_q  <= rd_i;
      res_q <= early_res;
      neg_q <= muldiv_pkg::op_is_rem(op_i) ? a_neg : (a_neg ^ b_neg);
      if (muldiv_pkg::op_is_div(op_i)) begin
        work_q <= {{XLEN{1'b0}}, a_mag};
        opnd_q <= b_mag;
      end else begin
        work_q <= {{XLEN{1'b0}}, b_mag};
        opnd_q <= a_mag;
      end
    end else if (state_q == muldiv_pkg::CALC) begin
      if (cnt_q == CNT_W'(XLEN)) begin
        res_q <= part_sel;
      end else begin
        work_q <= work_step;
      end
    end
  end

  assign rsp_valid_o = (state_q == muldiv_pkg::DONE);
  assign rsp_rd_o    = rd_q;
  assign rsp_data_o  = res_q;

endmodule

`default_nettype wire
